// File: sim.f
rtl/ahbMatrixPkg.sv
rtl/matrixIfs.sv
rtl/requestDecoder.sv
rtl/accessTracker.sv
rtl/portMux.sv
rtl/masterPort.sv
testbench/tbMasterPort.sv

// File: Bender.yml
package:
  name: ahb_master_port

sources:
  - rtl/ahbMatrixPkg.sv
  - rtl/matrixIfs.sv
  - rtl/requestDecoder.sv
  - rtl/accessTracker.sv
  - rtl/portMux.sv
  - rtl/masterPort.sv
  - target: simulation
    files:
      - testbench/tbMasterPort.sv

// File: testbench/tbMasterPort.sv
// Testbench for the AHB master port
// Models the master, four slaves and the layer grants
// Concurrent assertions check every response of the port

`timescale 1ns/1ps

module tbMasterPort
  import ahbMatrixPkg::*;
();

  // Read data tag of slave 0, slave i returns tag plus i
  localparam logic [DataWidth-1:0] SlaveTag = 32'hA5A5_0000;
  localparam int NumRandom     = 24;
  localparam int HoldCycles    = 3;
  // Rough upper length per test group
  localparam int TestCycles    = 6 + 3 * 4 + 3 * 5 + 3 * (HoldCycles + 5) + NumRandom * 6;
  localparam int TimeoutCycles = 4 * TestCycles;

  logic                                HCLK;
  logic                                HRESETn;
  logic                                HSEL;
  logic [AddrWidth-1:0]                HADDR;
  logic [DataWidth-1:0]                HWDATA;
  logic                                HWRITE;
  logic [2:0]                          HSIZE;
  logic [2:0]                          HBURST;
  logic [3:0]                          HPROT;
  logic [1:0]                          HTRANS;
  logic                                HMASTLOCK;
  logic                                HREADY;
  logic [DataWidth-1:0]                HRDATA;
  logic                                HREADYOUT;
  logic                                HRESP;
  logic [NumSlaves-1:0]                slvHSEL;
  logic [AddrWidth-1:0]                slvHADDR;
  logic [DataWidth-1:0]                slvHWDATA;
  logic                                slvHWRITE;
  logic [2:0]                          slvHSIZE;
  logic [2:0]                          slvHBURST;
  logic [3:0]                          slvHPROT;
  logic [1:0]                          slvHTRANS;
  logic                                slvHMASTLOCK;
  logic                                slvHREADYOUT;
  logic [NumSlaves-1:0][DataWidth-1:0] slvHRDATA;
  logic [NumSlaves-1:0]                slvHREADY;
  logic [NumSlaves-1:0]                slvHRESP;
  logic [NumSlaves-1:0]                masterGranted;

  // Check windows, set on falling edges
  logic                 afterReset;
  logic                 presenting;
  logic                 liveCheck;
  logic                 dataActive;
  logic                 errAccept;
  logic                 holding;
  logic                 grantEdge;
  logic [1:0]           errStage;
  int                   expSlave;
  logic [NumSlaves-1:0] expSel;
  logic [AddrWidth-1:0] holdAddr;
  logic [DataWidth-1:0] expWdata;
  logic [1:0]           expTrans;
  // Slave model and random source
  logic                 randomWaits;
  logic [NumSlaves-1:0] readyDraw;
  logic [NumSlaves-1:0] respDraw;
  logic [31:0]          waitBits;
  logic [31:0]          lfsr;
  int                   cycleCount;

  // Only master on this layer, so HREADY loops back
  assign HREADY = HREADYOUT;

  masterPort u_dut (.*);

  always #50 HCLK = ~HCLK;

  //////////////////////////////
  // Helpers
  //////////////////////////////
  // Galois step, taps 32 22 2 1
  function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic takeBits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++)
    begin
      bits[i] = lfsr[0];
      lfsr = nextLfsr(lfsr);
    end
  endtask

  // Word aligned address in one 256 MB region
  function automatic logic [AddrWidth-1:0] regionAddr(input int region, input logic [31:0] bits);
    return {4'(region), bits[25:0], 2'b00};
  endfunction

  task automatic stopRun(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    stopRun($sformatf("FAILED at %0t ns: %s expected %0h, actual %0h", $time, name,
                      expected, actual));
  endtask

  // Sampled on rising edges, nothing changes there before the NBA region
  task automatic waitReady();
    do
      @(posedge HCLK);
    while (HREADYOUT !== 1'b1);
  endtask

  //////////////////////////////
  // Transfer sequences
  //////////////////////////////
  task automatic grantedTransfer(input int slave);
    logic [31:0] bits;
    takeBits(26, bits);
    @(negedge HCLK);
    HSEL       = 1'b1;
    HADDR      = regionAddr(slave, bits);
    HTRANS     = TransNonseq;
    HBURST     = BurstSingle;
    takeBits(1, bits);
    HWRITE     = bits[0];
    expSlave   = slave;
    expSel     = '0;
    expSel[slave] = 1'b1;
    liveCheck  = 1'b1;
    presenting = 1'b1;
    @(negedge HCLK);
    takeBits(32, bits);
    // Data phase, next address phase idle
    HWDATA     = bits;
    expWdata   = bits;
    HSEL       = 1'b0;
    HTRANS     = TransIdle;
    liveCheck  = 1'b0;
    presenting = 1'b0;
    dataActive = 1'b1;
    waitReady();
    @(negedge HCLK);
    dataActive = 1'b0;
  endtask

  // Unmapped or masked address
  task automatic errorAccess(input logic [AddrWidth-1:0] addr);
    @(negedge HCLK);
    HSEL       = 1'b1;
    HADDR      = addr;
    HTRANS     = TransNonseq;
    presenting = 1'b1;
    errAccept  = 1'b1;
    @(negedge HCLK);
    HSEL       = 1'b0;
    HTRANS     = TransIdle;
    presenting = 1'b0;
    errAccept  = 1'b0;
    // Both error cycles
    repeat (2) @(negedge HCLK);
  endtask

  // Transfer while the layer belongs to another master
  task automatic heldAccess(input int slave, input logic [1:0] trans, input logic [2:0] burst);
    logic [31:0] bits;
    takeBits(26, bits);
    @(negedge HCLK);
    masterGranted = '0;
    HSEL       = 1'b1;
    HADDR      = regionAddr(slave, bits);
    HTRANS     = trans;
    HBURST     = burst;
    presenting = 1'b1;
    @(negedge HCLK);
    holdAddr   = HADDR;
    // Held INCR beat replays as a new burst
    expTrans   = (trans == TransSeq && burst == BurstIncr) ? TransNonseq : trans;
    expSlave   = slave;
    expSel     = '0;
    expSel[slave] = 1'b1;
    HSEL       = 1'b0;
    HTRANS     = TransIdle;
    HBURST     = BurstSingle;
    presenting = 1'b0;
    holding    = 1'b1;
    repeat (HoldCycles) @(negedge HCLK);
    masterGranted[slave] = 1'b1;
    grantEdge  = 1'b1;
    @(negedge HCLK);
    grantEdge  = 1'b0;
    holding    = 1'b0;
    waitReady();
    @(negedge HCLK);
    masterGranted = '1;
  endtask

  //////////////////////////////
  // Slave model and timers
  //////////////////////////////
  // Wait states drawn on the rising edge
  always @(posedge HCLK)
  begin
    if (randomWaits)
    begin
      takeBits(NumSlaves, waitBits);
      readyDraw = waitBits[NumSlaves-1:0];
      takeBits(NumSlaves, waitBits);
      respDraw  = waitBits[NumSlaves-1:0];
    end
    else
    begin
      readyDraw = '1;
      respDraw  = '0;
    end
  end

  always @(negedge HCLK)
  begin
    slvHREADY <= readyDraw;
    slvHRESP  <= respDraw;
  end

  // Error acceptance delayed into the two response cycles
  always @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      errStage <= '0;
    else
      errStage <= {errStage[0], errAccept};
  end

  always @(posedge HCLK)
  begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles)
      stopRun($sformatf("Timeout: the tests did not end within %0d cycles", TimeoutCycles));
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  resetReady: assert property (@(posedge HCLK) afterReset |-> HREADYOUT == 1'b1)
    else reportMismatch("HREADYOUT", 1, $sampled(HREADYOUT));
  resetResp: assert property (@(posedge HCLK) afterReset |-> HRESP == RespOkay)
    else reportMismatch("HRESP", RespOkay, $sampled(HRESP));
  resetSelect: assert property (@(posedge HCLK) afterReset |-> slvHSEL == '0)
    else reportMismatch("slvHSEL", 0, $sampled(slvHSEL));

  // Every new phase meets a ready port
  acceptReady: assert property (@(posedge HCLK) disable iff (!HRESETn)
    presenting |-> HREADYOUT == 1'b1)
    else reportMismatch("HREADYOUT", 1, $sampled(HREADYOUT));

  liveSelect: assert property (@(posedge HCLK) disable iff (!HRESETn)
    liveCheck |-> slvHSEL == expSel)
    else reportMismatch("slvHSEL", expSel, $sampled(slvHSEL));
  liveAddr: assert property (@(posedge HCLK) disable iff (!HRESETn)
    liveCheck |-> slvHADDR == HADDR)
    else reportMismatch("slvHADDR", $sampled(HADDR), $sampled(slvHADDR));
  liveTrans: assert property (@(posedge HCLK) disable iff (!HRESETn)
    liveCheck |-> slvHTRANS == TransNonseq)
    else reportMismatch("slvHTRANS", TransNonseq, $sampled(slvHTRANS));
  // Write, size, burst, protection and lock in one word
  liveControl: assert property (@(posedge HCLK) disable iff (!HRESETn)
    liveCheck |-> {slvHWRITE, slvHSIZE, slvHBURST, slvHPROT, slvHMASTLOCK} ==
                  {HWRITE, HSIZE, HBURST, HPROT, HMASTLOCK})
    else reportMismatch("slave control",
                        $sampled({HWRITE, HSIZE, HBURST, HPROT, HMASTLOCK}),
                        $sampled({slvHWRITE, slvHSIZE, slvHBURST, slvHPROT, slvHMASTLOCK}));
  liveReadyOut: assert property (@(posedge HCLK) disable iff (!HRESETn)
    liveCheck |-> slvHREADYOUT == slvHREADY[expSlave])
    else reportMismatch("slvHREADYOUT", $sampled(slvHREADY[expSlave]),
                        $sampled(slvHREADYOUT));

  readData: assert property (@(posedge HCLK) disable iff (!HRESETn)
    dataActive && HREADYOUT |-> HRDATA == SlaveTag + DataWidth'(expSlave))
    else reportMismatch("HRDATA", SlaveTag + DataWidth'(expSlave), $sampled(HRDATA));
  dataReady: assert property (@(posedge HCLK) disable iff (!HRESETn)
    dataActive |-> HREADYOUT == slvHREADY[expSlave])
    else reportMismatch("HREADYOUT", $sampled(slvHREADY[expSlave]), $sampled(HREADYOUT));
  dataResp: assert property (@(posedge HCLK) disable iff (!HRESETn)
    dataActive |-> HRESP == slvHRESP[expSlave])
    else reportMismatch("HRESP", $sampled(slvHRESP[expSlave]), $sampled(HRESP));
  dataWrite: assert property (@(posedge HCLK) disable iff (!HRESETn)
    dataActive |-> slvHWDATA == expWdata)
    else reportMismatch("slvHWDATA", expWdata, $sampled(slvHWDATA));

  errNoSelect: assert property (@(posedge HCLK) disable iff (!HRESETn)
    errAccept |-> slvHSEL == '0)
    else reportMismatch("slvHSEL", 0, $sampled(slvHSEL));
  errFirstReady: assert property (@(posedge HCLK) disable iff (!HRESETn)
    errStage[0] |-> HREADYOUT == 1'b0)
    else reportMismatch("HREADYOUT", 0, $sampled(HREADYOUT));
  errFirstResp: assert property (@(posedge HCLK) disable iff (!HRESETn)
    errStage[0] |-> HRESP == RespError)
    else reportMismatch("HRESP", RespError, $sampled(HRESP));
  errSecondReady: assert property (@(posedge HCLK) disable iff (!HRESETn)
    errStage[1] |-> HREADYOUT == 1'b1)
    else reportMismatch("HREADYOUT", 1, $sampled(HREADYOUT));
  errSecondResp: assert property (@(posedge HCLK) disable iff (!HRESETn)
    errStage[1] |-> HRESP == RespError)
    else reportMismatch("HRESP", RespError, $sampled(HRESP));

  heldWait: assert property (@(posedge HCLK) disable iff (!HRESETn)
    holding |-> HREADYOUT == 1'b0)
    else reportMismatch("HREADYOUT", 0, $sampled(HREADYOUT));
  heldSelect: assert property (@(posedge HCLK) disable iff (!HRESETn)
    holding |-> slvHSEL == expSel)
    else reportMismatch("slvHSEL", expSel, $sampled(slvHSEL));
  heldAddr: assert property (@(posedge HCLK) disable iff (!HRESETn)
    holding |-> slvHADDR == holdAddr)
    else reportMismatch("slvHADDR", holdAddr, $sampled(slvHADDR));
  heldTrans: assert property (@(posedge HCLK) disable iff (!HRESETn)
    holding |-> slvHTRANS == expTrans)
    else reportMismatch("slvHTRANS", expTrans, $sampled(slvHTRANS));
  heldReadyOut: assert property (@(posedge HCLK) disable iff (!HRESETn)
    holding |-> slvHREADYOUT == slvHREADY[expSlave])
    else reportMismatch("slvHREADYOUT", $sampled(slvHREADY[expSlave]),
                        $sampled(slvHREADYOUT));
  // Grant plus ready slave ends the wait one cycle later
  grantReady: assert property (@(posedge HCLK) disable iff (!HRESETn)
    grantEdge |=> HREADYOUT == 1'b1)
    else reportMismatch("HREADYOUT", 1, $sampled(HREADYOUT));

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial
  begin
    logic [31:0] bits;
    int          pick;
    HCLK          = 1'b0;
    HRESETn       = 1'b1;
    HSEL          = 1'b0;
    HADDR         = '0;
    HWDATA        = '0;
    HWRITE        = 1'b0;
    HSIZE         = 3'b010;
    HBURST        = BurstSingle;
    HPROT         = 4'b0011;
    HTRANS        = TransIdle;
    HMASTLOCK     = 1'b0;
    masterGranted = '1;
    slvHREADY     = '1;
    slvHRESP      = '0;
    for (int i = 0; i < NumSlaves; i++)
      slvHRDATA[i] = SlaveTag + DataWidth'(i);
    readyDraw     = '1;
    respDraw      = '0;
    randomWaits   = 1'b0;
    afterReset    = 1'b1;
    presenting    = 1'b0;
    liveCheck     = 1'b0;
    dataActive    = 1'b0;
    errAccept     = 1'b0;
    holding       = 1'b0;
    grantEdge     = 1'b0;
    expSlave      = 0;
    expSel        = '0;
    holdAddr      = '0;
    expWdata      = '0;
    expTrans      = TransIdle;
    lfsr          = 32'h2f9d;
    cycleCount    = 0;

    #1 HRESETn = 1'b0;
    repeat (4) @(negedge HCLK);
    HRESETn = 1'b1;
    @(negedge HCLK);
    afterReset = 1'b0;

    // Layer granted, slaves without wait states
    grantedTransfer(0);
    grantedTransfer(1);
    grantedTransfer(3);

    // Two unmapped regions, then masked slave 2
    errorAccess(32'h4000_0040);
    errorAccess(32'hF000_1000);
    takeBits(26, bits);
    errorAccess(regionAddr(2, bits));

    // Held phases, only the INCR beat is rewritten
    heldAccess(0, TransNonseq, BurstSingle);
    heldAccess(1, TransSeq, BurstIncr);
    heldAccess(3, TransSeq, BurstIncr4);

    // Random wait states and responses
    randomWaits = 1'b1;
    repeat (NumRandom)
    begin
      takeBits(2, bits);
      pick = (bits[1:0] == 2'd2) ? 3 : int'(bits[1:0]);
      grantedTransfer(pick);
    end
    randomWaits = 1'b0;

    @(negedge HCLK);
    $display("all tests passed");
    $finish;
  end

endmodule

// File: rtl/masterPort.sv
// AHB3-Lite multi-layer switch master port
// Decodes one master's transfers onto four slave ports, holds the phase
// until the slave layer is granted and errors unmapped or masked accesses

`timescale 1ns/1ps

module masterPort
  import ahbMatrixPkg::*;
(
  input  logic                                HCLK,
  input  logic                                HRESETn,
  // Master side
  input  logic                                HSEL,
  input  logic [AddrWidth-1:0]                HADDR,
  input  logic [DataWidth-1:0]                HWDATA,
  input  logic                                HWRITE,
  input  logic [2:0]                          HSIZE,
  input  logic [2:0]                          HBURST,
  input  logic [3:0]                          HPROT,
  input  logic [1:0]                          HTRANS,
  input  logic                                HMASTLOCK,
  input  logic                                HREADY,
  output logic [DataWidth-1:0]                HRDATA,
  output logic                                HREADYOUT,
  output logic                                HRESP,
  // Slave side
  output logic [NumSlaves-1:0]                slvHSEL,
  output logic [AddrWidth-1:0]                slvHADDR,
  output logic [DataWidth-1:0]                slvHWDATA,
  output logic                                slvHWRITE,
  output logic [2:0]                          slvHSIZE,
  output logic [2:0]                          slvHBURST,
  output logic [3:0]                          slvHPROT,
  output logic [1:0]                          slvHTRANS,
  output logic                                slvHMASTLOCK,
  output logic                                slvHREADYOUT,
  input  logic [NumSlaves-1:0][DataWidth-1:0] slvHRDATA,
  input  logic [NumSlaves-1:0]                slvHREADY,
  input  logic [NumSlaves-1:0]                slvHRESP,
  // Layer grants from the slave-side arbiters
  input  logic [NumSlaves-1:0]                masterGranted
);

  // Tracker state toward the mux
  logic                     accessPending;
  logic                     accessGranted;
  logic [SlaveIdxWidth-1:0] slaveIdx;

  // Decode and held phase buses
  selectIf    sel ();
  heldPhaseIf held ();

  requestDecoder uDecoder (.*);

  accessTracker uTracker (.*);

  portMux uMux (.*);

endmodule

// File: rtl/portMux.sv
// Port multiplexer of the master port
// Steers the live or held phase to the slaves and the slave or local
// response back to the master

`timescale 1ns/1ps

module portMux
  import ahbMatrixPkg::*;
(
  input  logic                                accessPending,
  input  logic                                accessGranted,
  input  logic [SlaveIdxWidth-1:0]            slaveIdx,
  selectIf.mux                                sel,
  heldPhaseIf.mux                             held,
  input  logic [AddrWidth-1:0]                HADDR,
  input  logic [DataWidth-1:0]                HWDATA,
  input  logic                                HWRITE,
  input  logic [2:0]                          HSIZE,
  input  logic [2:0]                          HBURST,
  input  logic [3:0]                          HPROT,
  input  logic [1:0]                          HTRANS,
  input  logic                                HMASTLOCK,
  input  logic                                HREADY,
  input  logic [NumSlaves-1:0][DataWidth-1:0] slvHRDATA,
  input  logic [NumSlaves-1:0]                slvHREADY,
  input  logic [NumSlaves-1:0]                slvHRESP,
  output logic [AddrWidth-1:0]                slvHADDR,
  output logic [DataWidth-1:0]                slvHWDATA,
  output logic                                slvHWRITE,
  output logic [2:0]                          slvHSIZE,
  output logic [2:0]                          slvHBURST,
  output logic [3:0]                          slvHPROT,
  output logic [1:0]                          slvHTRANS,
  output logic                                slvHMASTLOCK,
  output logic                                slvHREADYOUT,
  output logic [DataWidth-1:0]                HRDATA,
  output logic                                HREADYOUT,
  output logic                                HRESP
);

  // Held INCR beat restarts as a new burst
  logic heldIncrSeq;

  assign heldIncrSeq = (held.htrans == TransSeq) && (held.hburst == BurstIncr);

  //////////////////////////////
  // Toward the slaves
  //////////////////////////////
  assign slvHADDR     = accessPending ? held.haddr     : HADDR;
  assign slvHWDATA    = accessPending ? held.hwdata    : HWDATA;
  assign slvHWRITE    = accessPending ? held.hwrite    : HWRITE;
  assign slvHSIZE     = accessPending ? held.hsize     : HSIZE;
  assign slvHBURST    = accessPending ? held.hburst    : HBURST;
  assign slvHPROT     = accessPending ? held.hprot     : HPROT;
  assign slvHMASTLOCK = accessPending ? held.hmastlock : HMASTLOCK;
  assign slvHTRANS    = !accessPending ? HTRANS      :
                        heldIncrSeq    ? TransNonseq : held.htrans;

  // Live phase accepted only with the addressed slave ready
  assign slvHREADYOUT = accessPending ? slvHREADY[slaveIdx] :
                        HREADY && |(sel.currentSel & slvHREADY);

  //////////////////////////////
  // Toward the master
  //////////////////////////////
  assign HRDATA    = slvHRDATA[slaveIdx];
  assign HREADYOUT = accessGranted ? slvHREADY[slaveIdx] : sel.localReady;
  assign HRESP     = accessGranted ? slvHRESP[slaveIdx]  : sel.localResp;

endmodule

// File: rtl/accessTracker.sv
// Access tracker of the master port
// Follows whether the slave layer is granted, drives the slave selects
// and remembers which slave owns the data phase

`timescale 1ns/1ps

module accessTracker
  import ahbMatrixPkg::*;
(
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  logic                     HSEL,
  input  logic                     HREADY,
  input  logic [NumSlaves-1:0]     masterGranted,
  input  logic [NumSlaves-1:0]     slvHREADY,
  selectIf.tracker                 sel,
  output logic [NumSlaves-1:0]     slvHSEL,
  output logic                     accessPending,
  output logic                     accessGranted,
  output logic [SlaveIdxWidth-1:0] slaveIdx
);

  // One-hot state {granted, pending, noAccess}
  logic [2:0] state;
  logic       noAccess;

  // Index of the set bit, zero when none
  function automatic logic [SlaveIdxWidth-1:0] oneHotToIdx(input logic [NumSlaves-1:0] oneHot);
    logic [SlaveIdxWidth-1:0] idx;
    idx = '0;
    for (int i = 1; i < NumSlaves; i++)
    begin
      if (oneHot[i])
        idx = SlaveIdxWidth'(i);
    end
    return idx;
  endfunction

  assign noAccess      = state[0];
  assign accessPending = state[1];
  assign accessGranted = state[2];

  //////////////////////////////
  // Access FSM
  //////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      state <= 3'b001;
    else
    begin
      case (1'b1)
        noAccess:
          if (sel.currentSel == '0 && sel.pendingSel == '0)
            state <= 3'b001;
          else if (|(sel.currentSel & masterGranted))
            state <= 3'b100;
          else
            state <= 3'b010;
        // Replay once the layer is ours and the slave is ready
        accessPending:
          if (|(sel.pendingSel & masterGranted) && slvHREADY[slaveIdx])
            state <= 3'b100;
        accessGranted:
          if (HREADY && sel.currentSel == '0)
            state <= 3'b001;
          else if (HREADY && ~|(sel.currentSel & masterGranted & slvHREADY))
            state <= 3'b010;
        default:
          state <= 3'b001;
      endcase
    end
  end

  // Held decode while waiting, live decode otherwise
  assign slvHSEL = accessPending ? sel.pendingSel : ({NumSlaves{HSEL}} & sel.currentSel);

  // Slave owning the next data phase
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      slaveIdx <= '0;
    else if (HREADY)
      slaveIdx <= oneHotToIdx(slvHSEL);
  end

  stateOneHot: assert property (@(posedge HCLK) disable iff (!HRESETn) $onehot(state));
  // Disjoint regions give one slave at most
  selectOneHot: assert property (@(posedge HCLK) disable iff (!HRESETn) $onehot0(slvHSEL));

endmodule

// File: rtl/requestDecoder.sv
// Request decoder of the master port
// Holds the address phase, decodes slave selects against the address map
// and answers idle, wait and error cycles locally

`timescale 1ns/1ps

module requestDecoder
  import ahbMatrixPkg::*;
(
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  logic                 HSEL,
  input  logic [AddrWidth-1:0] HADDR,
  input  logic [DataWidth-1:0] HWDATA,
  input  logic                 HWRITE,
  input  logic [2:0]           HSIZE,
  input  logic [2:0]           HBURST,
  input  logic [3:0]           HPROT,
  input  logic [1:0]           HTRANS,
  input  logic                 HMASTLOCK,
  input  logic                 HREADY,
  selectIf.decoder             sel,
  heldPhaseIf.holder           held
);

  logic [NumSlaves-1:0] liveSel;
  logic [NumSlaves-1:0] heldSel;
  logic [NumSlaves-1:0] maskedHit;
  logic [NumSlaves-1:0] noSlaveHit;
  logic                 liveActive;
  logic                 takeError;
  // High during the first error cycle
  logic                 errorPhase;

  // Address inside region idx
  function automatic logic regionHit(input logic [AddrWidth-1:0] addr, input int idx);
    return (addr & SlaveMask[idx]) == (SlaveBase[idx] & SlaveMask[idx]);
  endfunction

  //////////////////////////////
  // Held address phase
  //////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      held.htrans <= TransIdle;
    else if (HREADY)
      held.htrans <= HSEL ? HTRANS : TransIdle;
  end

  // Payload only, loaded with every accepted phase
  always_ff @(posedge HCLK)
  begin
    if (HREADY)
    begin
      held.haddr     <= HADDR;
      held.hwdata    <= HWDATA;
      held.hwrite    <= HWRITE;
      held.hsize     <= HSIZE;
      held.hburst    <= HBURST;
      held.hprot     <= HPROT;
      held.hmastlock <= HMASTLOCK;
    end
  end

  //////////////////////////////
  // Address decode
  //////////////////////////////
  assign liveActive = HSEL && (HTRANS != TransIdle);

  always_comb
  begin
    for (int s = 0; s < NumSlaves; s++)
    begin
      // No new select while an error response runs
      liveSel[s]    = SlaveEnable[s] && liveActive && regionHit(HADDR, s) &&
                      !errorPhase;
      heldSel[s]    = SlaveEnable[s] && (held.htrans != TransIdle) &&
                      regionHit(held.haddr, s);
      // Masked slave hit
      maskedHit[s]  = !SlaveEnable[s] && ErrorOnMasked[s] && liveActive &&
                      regionHit(HADDR, s);
      // Outside region s
      noSlaveHit[s] = ErrorOnNoSlave && liveActive && !regionHit(HADDR, s);
    end
  end

  // Unmapped when outside all regions
  assign takeError      = |maskedHit || &noSlaveHit;
  assign sel.currentSel = liveSel;
  assign sel.pendingSel = heldSel;

  //////////////////////////////
  // Local response FSM
  //////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      errorPhase     <= 1'b0;
      sel.localReady <= 1'b1;
      sel.localResp  <= RespOkay;
    end
    else if (errorPhase)
    begin
      // Second error cycle
      errorPhase     <= 1'b0;
      sel.localReady <= 1'b1;
      sel.localResp  <= RespError;
    end
    else if (HREADY)
    begin
      // Idle or not selected completes at once
      if (!liveActive)
      begin
        sel.localReady <= 1'b1;
        sel.localResp  <= RespOkay;
      end
      else if (takeError)
      begin
        // First error cycle
        errorPhase     <= 1'b1;
        sel.localReady <= 1'b0;
        sel.localResp  <= RespError;
      end
      else
      begin
        // Wait until the slave side takes over
        sel.localReady <= 1'b0;
        sel.localResp  <= RespOkay;
      end
    end
  end

  // Waiting error cycle always followed by the ready one
  errorSecondCycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !sel.localReady && (sel.localResp == RespError) |=>
    sel.localReady && (sel.localResp == RespError));

endmodule

// File: rtl/matrixIfs.sv
// Internal buses of the master port
// Slave select decode with local response, and the held address phase

`timescale 1ns/1ps

// Decode results and the port's own response
interface selectIf
  import ahbMatrixPkg::*;
();
  // Decode of the live address
  logic [NumSlaves-1:0] currentSel;
  // Decode of the held address
  logic [NumSlaves-1:0] pendingSel;
  // Local HREADYOUT and HRESP
  logic                 localReady;
  logic                 localResp;

  modport decoder (output currentSel, output pendingSel, output localReady, output localResp);
  modport tracker (input currentSel, input pendingSel);
  modport mux (input currentSel, input localReady, input localResp);
endinterface

// Registered copy of the master's address phase
interface heldPhaseIf
  import ahbMatrixPkg::*;
();
  logic [AddrWidth-1:0] haddr;
  logic [DataWidth-1:0] hwdata;
  logic                 hwrite;
  logic [2:0]           hsize;
  logic [2:0]           hburst;
  logic [3:0]           hprot;
  logic [1:0]           htrans;
  logic                 hmastlock;

  modport holder (output haddr, output hwdata, output hwrite, output hsize,
                  output hburst, output hprot, output htrans, output hmastlock);
  modport mux (input haddr, input hwdata, input hwrite, input hsize,
               input hburst, input hprot, input htrans, input hmastlock);
endinterface

// File: rtl/ahbMatrixPkg.sv
// AHB matrix shared definitions
// Bus widths, AHB transfer encodings and the fixed slave address map

package ahbMatrixPkg;

  //////////////////////////////
  // Bus sizes
  //////////////////////////////
  localparam int AddrWidth     = 32;
  localparam int DataWidth     = 32;
  localparam int NumSlaves     = 4;
  localparam int SlaveIdxWidth = 2;

  //////////////////////////////
  // Slave address map
  //////////////////////////////
  // One 256 MB region per slave
  localparam logic [AddrWidth-1:0] SlaveBase [NumSlaves] = '{
    32'h0000_0000,
    32'h1000_0000,
    32'h2000_0000,
    32'h3000_0000
  };
  localparam logic [AddrWidth-1:0] SlaveMask [NumSlaves] = '{
    32'hF000_0000,
    32'hF000_0000,
    32'hF000_0000,
    32'hF000_0000
  };

  // Slave 2 can never be addressed
  localparam logic [NumSlaves-1:0] SlaveEnable    = 4'b1011;
  localparam logic [NumSlaves-1:0] ErrorOnMasked  = ~SlaveEnable;
  localparam logic                 ErrorOnNoSlave = 1'b1;

  //////////////////////////////
  // AHB encodings
  //////////////////////////////
  // HTRANS
  localparam logic [1:0] TransIdle   = 2'b00;
  localparam logic [1:0] TransBusy   = 2'b01;
  localparam logic [1:0] TransNonseq = 2'b10;
  localparam logic [1:0] TransSeq    = 2'b11;

  // HBURST
  localparam logic [2:0] BurstSingle = 3'b000;
  localparam logic [2:0] BurstIncr   = 3'b001;
  localparam logic [2:0] BurstWrap4  = 3'b010;
  localparam logic [2:0] BurstIncr4  = 3'b011;
  localparam logic [2:0] BurstWrap8  = 3'b100;
  localparam logic [2:0] BurstIncr8  = 3'b101;
  localparam logic [2:0] BurstWrap16 = 3'b110;
  localparam logic [2:0] BurstIncr16 = 3'b111;

  // HRESP
  localparam logic RespOkay  = 1'b0;
  localparam logic RespError = 1'b1;

endpackage
